// File: memAccess.f
design/memAccessPkg.sv
design/syncFifo.sv
design/byteRam.sv
design/memCtrl.sv
design/requestSlot.sv
design/memAccessTop.sv
verif/memAccessTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memAccessTb
FILELIST = memAccess.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/memAccessTb.sv
`timescale 1ns/10ps
`default_nettype none

module memAccessTb;

    import memAccessPkg::*;

    localparam int addrWidth = 10;
    localparam int fifoDepth = 4;
    localparam int clkPeriod = 100;
    localparam int numTests  = 5;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 reqEn;
    logic                 reqReady;
    logic                 reqStore;
    logic [31:0]          reqAddr;
    logic [dataWidth-1:0] reqData;
    lenT                  reqLen;
    logic [nickWidth-1:0] reqNick;
    logic                 respValid;
    logic                 respReady;
    logic [dataWidth-1:0] respData;
    logic [nickWidth-1:0] respNick;

    // Byte image of the RAM, updated when a store is sent.
    logic [7:0]           model [1 << addrWidth];
    memReqT               pendQ [$];
    logic [dataWidth-1:0] expData [$];
    logic [nickWidth-1:0] expNick [$];
    logic [nickWidth-1:0] nextNick;
    logic                 holdResp;
    int                   accepted;
    int                   errors;
    int                   failedTests;

    memAccessTop #(.addrWidth(addrWidth), .fifoDepth(fifoDepth)) i_dut (
        .clk(clk), .rst(rst), .rdy(rdy),
        .reqEn(reqEn), .reqReady(reqReady), .reqStore(reqStore), .reqAddr(reqAddr),
        .reqData(reqData), .reqLen(reqLen), .reqNick(reqNick),
        .respValid(respValid), .respReady(respReady), .respData(respData),
        .respNick(respNick)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // **************************************************
    // Stimulus and reference model
    // **************************************************

    // Little-endian bytes, zero-extended, address wrapping at the RAM size.
    task automatic applyRequest(input memReqT r);
        logic [addrWidth-1:0] idx;
        logic [dataWidth-1:0] val;
        int                   n;
        int                   i;
        n = (r.len == lenByte) ? 1 : (r.len == lenHalf) ? 2 : 4;
        val = '0;
        for (i = 0; i < n; i++) begin
            idx = r.addr[addrWidth-1:0] + addrWidth'(i);
            if (r.store) begin
                model[idx] = 8'(r.data >> (8 * i));
            end else begin
                val = val | (32'(model[idx]) << (8 * i));
            end
        end
        expData.push_back(val);
        expNick.push_back(r.nick);
    endtask

    task automatic queueReq(input logic isStore, input logic [31:0] addr,
                            input logic [dataWidth-1:0] data, input lenT len);
        memReqT r;
        r.store = isStore;
        r.addr  = addr;
        r.data  = data;
        r.len   = len;
        r.nick  = nextNick;
        pendQ.push_back(r);
        nextNick = nextNick + 1'b1;
    endtask

    task automatic checkResponse();
        logic [dataWidth-1:0] wantData;
        logic [nickWidth-1:0] wantNick;
        assert (expData.size() > 0) else begin
            $display("A response arrived at %0t ns with no request outstanding", $time);
            errors++;
        end
        if (expData.size() > 0) begin
            wantData = expData.pop_front();
            wantNick = expNick.pop_front();
            assert (respData === wantData && respNick === wantNick) else begin
                $display("Error %0t ns: response %h nick %0d, expected %h nick %0d",
                         $time, respData, respNick, wantData, wantNick);
                errors++;
            end
        end
    endtask

    // Outputs are sampled at the falling edge, then the inputs for the next edge are driven.
    task automatic cycle();
        memReqT r;
        @(negedge clk);
        respReady = !holdResp;
        if (respValid && respReady) begin
            checkResponse();
        end
        reqEn = 1'b0;
        if (pendQ.size() > 0 && reqReady) begin
            r = pendQ.pop_front();
            reqEn    = 1'b1;
            reqStore = r.store;
            reqAddr  = r.addr;
            reqData  = r.data;
            reqLen   = r.len;
            reqNick  = r.nick;
            applyRequest(r);
            accepted++;
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        holdResp = 1'b0;
        while ((pendQ.size() > 0 || expData.size() > 0) && guard < 1000) begin
            cycle();
            guard++;
        end
        assert (guard < 1000) else begin
            $display("Responses were still missing after %0d cycles at %0t ns", guard, $time);
            errors++;
        end
        // Idle cycles expose any extra response.
        repeat (8) cycle();
    endtask

    task automatic expectSilence(input int cycles);
        repeat (cycles) begin
            cycle();
            assert (!respValid) else begin
                $display("Error %0t ns: response appeared while rdy was low", $time);
                errors++;
            end
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errors == startErrors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - startErrors);
            failedTests++;
        end
    endtask

    // **************************************************
    // Directed tests
    // **************************************************

    task automatic resetStateTest();
        int startErrors;
        startErrors = errors;
        @(negedge clk);
        assert (respValid === 1'b0 && reqReady === 1'b1) else begin
            $display("Error %0t ns: after reset respValid %b reqReady %b",
                     $time, respValid, reqReady);
            errors++;
        end
        reportTest("reset state", startErrors);
    endtask

    task automatic wordRoundTripTest();
        logic [31:0] addrs [8];
        int          startErrors;
        int          i;
        startErrors = errors;
        for (i = 0; i < 8; i++) begin
            addrs[i] = $urandom() & 32'h0000_03fc;
            queueReq(1'b1, addrs[i], $urandom(), lenWord);
        end
        for (i = 0; i < 8; i++) begin
            queueReq(1'b0, addrs[i], '0, lenWord);
        end
        drain();
        reportTest("word round trip", startErrors);
    endtask

    task automatic mergeAndWrapTest();
        int startErrors;
        startErrors = errors;
        queueReq(1'b1, 32'h100, 32'h4433_2211, lenWord);
        queueReq(1'b1, 32'h104, 32'h8877_6655, lenWord);
        queueReq(1'b1, 32'h101, 32'h0000_00aa, lenByte);
        queueReq(1'b1, 32'h102, 32'h1234_beef, lenHalf);
        queueReq(1'b0, 32'h100, '0, lenByte);
        queueReq(1'b0, 32'h101, '0, lenByte);
        queueReq(1'b0, 32'h101, '0, lenHalf);
        queueReq(1'b0, 32'h103, '0, lenHalf);
        queueReq(1'b0, 32'h100, '0, lenWord);
        queueReq(1'b0, 32'h103, '0, lenWord);
        // This word runs past the top address into address zero.
        queueReq(1'b1, 32'h3fe, 32'hcafe_f00d, lenWord);
        queueReq(1'b0, 32'hffff_f7fe, '0, lenWord);
        queueReq(1'b0, 32'h3ff, '0, lenHalf);
        queueReq(1'b0, 32'h400, '0, lenByte);
        drain();
        reportTest("merge and wrap", startErrors);
    endtask

    task automatic backPressureTest();
        int startErrors;
        int startAccepted;
        int lowCycles;
        int guard;
        int i;
        startErrors   = errors;
        startAccepted = accepted;
        holdResp      = 1'b1;
        for (i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                queueReq(1'b1, 32'h200 + 4 * i, $urandom(), lenWord);
            end else begin
                queueReq(1'b0, 32'h200 + 4 * (i - 1), '0, lenWord);
            end
        end
        lowCycles = 0;
        guard     = 0;
        while (lowCycles < 40 && guard < 400) begin
            cycle();
            guard++;
            lowCycles = reqReady ? 0 : lowCycles + 1;
        end
        assert (lowCycles == 40) else begin
            $display("reqReady did not stay low while responses were held back");
            errors++;
        end
        assert (accepted - startAccepted <= 2 * fifoDepth + 1) else begin
            $display("Error %0t ns: %0d requests accepted under back-pressure",
                     $time, accepted - startAccepted);
            errors++;
        end
        drain();
        reportTest("back-pressure", startErrors);
    endtask

    task automatic rdyPauseTest();
        int startErrors;
        startErrors = errors;
        queueReq(1'b1, 32'h2f0, $urandom(), lenWord);
        queueReq(1'b1, 32'h2f4, $urandom(), lenWord);
        drain();
        // Pause as the load enters the request queue.
        queueReq(1'b0, 32'h2f0, '0, lenWord);
        cycle();
        rdy = 1'b0;
        expectSilence(40);
        rdy = 1'b1;
        drain();
        // Pause while the controller is part way through the bytes.
        queueReq(1'b0, 32'h2f2, '0, lenWord);
        repeat (6) cycle();
        rdy = 1'b0;
        expectSilence(40);
        rdy = 1'b1;
        drain();
        reportTest("rdy pause", startErrors);
    endtask

    // **************************************************
    // Main sequence and watchdog
    // **************************************************

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        rdy         = 1'b1;
        reqEn       = 1'b0;
        reqStore    = 1'b0;
        reqAddr     = '0;
        reqData     = '0;
        reqLen      = lenByte;
        reqNick     = '0;
        respReady   = 1'b0;
        holdResp    = 1'b0;
        nextNick    = '0;
        accepted    = 0;
        errors      = 0;
        failedTests = 0;
        void'($urandom(32'h3eb8_9ba8));
        repeat (16) @(negedge clk);
        rst = 1'b0;
        resetStateTest();
        wordRoundTripTest();
        mergeAndWrapTest();
        backPressureTest();
        rdyPauseTest();
        $display("%0d of %0d tests failed, %0d errors", failedTests, numTests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(numTests * 2000 * clkPeriod);
        $display("Timeout: the tests did not finish within %0d clock periods", numTests * 2000);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/memAccessTop.sv
`timescale 1ns/10ps
`default_nettype none

module memAccessTop #(
    parameter int addrWidth = 10,
    parameter int fifoDepth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    // Request port.
    input  logic                                reqEn,
    output logic                                reqReady,
    input  logic                                reqStore,
    input  logic [31:0]                         reqAddr,
    input  logic [memAccessPkg::dataWidth-1:0]  reqData,
    input  memAccessPkg::lenT                   reqLen,
    input  logic [memAccessPkg::nickWidth-1:0]  reqNick,
    // Response port.
    output logic                                respValid,
    input  logic                                respReady,
    output logic [memAccessPkg::dataWidth-1:0]  respData,
    output logic [memAccessPkg::nickWidth-1:0]  respNick
);

    import memAccessPkg::*;

    memReqT                 reqIn;
    logic                   reqFull;
    logic                   qValid;
    memReqT                 qReq;
    logic                   qPop;

    logic                   rspPush;
    memRespT                rspData;
    logic                   rspFull;
    memRespT                rspOut;

    logic                   mcEn;
    logic                   mcStore;
    logic [addrWidth-1:0]   mcAddr;
    logic [dataWidth-1:0]   mcData;
    lenT                    mcLen;
    logic                   mcBusy;
    logic                   mcDone;
    logic [dataWidth-1:0]   mcRdData;

    logic                   ramEn;
    logic                   ramWe;
    logic [addrWidth-1:0]   ramAddr;
    logic [7:0]             ramWrByte;
    logic [7:0]             ramRdByte;

    assign reqIn = '{store: reqStore, addr: reqAddr, data: reqData, len: reqLen, nick: reqNick};
    assign reqReady  = !reqFull;
    assign respData  = rspOut.data;
    assign respNick  = rspOut.nick;

    // **************************************************
    // Queues
    // **************************************************

    syncFifo #(.payloadT(memReqT), .depth(fifoDepth)) reqQueue (
        .clk(clk), .rst(rst),
        .push(reqEn && reqReady), .pushData(reqIn),
        .pop(qPop), .popData(qReq),
        .valid(qValid), .full(reqFull)
    );

    syncFifo #(.payloadT(memRespT), .depth(fifoDepth)) rspQueue (
        .clk(clk), .rst(rst),
        .push(rspPush), .pushData(rspData),
        .pop(respValid && respReady), .popData(rspOut),
        .valid(respValid), .full(rspFull)
    );

    // **************************************************
    // Access path
    // **************************************************

    requestSlot #(.addrWidth(addrWidth)) slot (
        .clk(clk), .rst(rst), .rdy(rdy),
        .qValid(qValid), .qReq(qReq), .qPop(qPop),
        .rspFull(rspFull), .rspPush(rspPush), .rspData(rspData),
        .mcBusy(mcBusy), .mcDone(mcDone), .mcRdData(mcRdData),
        .mcEn(mcEn), .mcStore(mcStore), .mcAddr(mcAddr),
        .mcData(mcData), .mcLen(mcLen)
    );

    memCtrl #(.addrWidth(addrWidth)) ctrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .mcEn(mcEn), .mcStore(mcStore), .mcAddr(mcAddr),
        .mcData(mcData), .mcLen(mcLen),
        .mcBusy(mcBusy), .mcDone(mcDone), .mcRdData(mcRdData),
        .ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr),
        .ramWrByte(ramWrByte), .ramRdByte(ramRdByte)
    );

    byteRam #(.addrWidth(addrWidth)) ram (
        .clk(clk),
        .ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr),
        .ramWrByte(ramWrByte), .ramRdByte(ramRdByte)
    );

endmodule

`default_nettype wire

// File: design/requestSlot.sv
`timescale 1ns/10ps
`default_nettype none

module requestSlot #(
    parameter int addrWidth = 10
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    // Request queue side.
    input  logic                                qValid,
    input  memAccessPkg::memReqT                qReq,
    output logic                                qPop,
    // Response queue side.
    input  logic                                rspFull,
    output logic                                rspPush,
    output memAccessPkg::memRespT               rspData,
    // Memory controller side.
    input  logic                                mcBusy,
    input  logic                                mcDone,
    input  logic [memAccessPkg::dataWidth-1:0]  mcRdData,
    output logic                                mcEn,
    output logic                                mcStore,
    output logic [addrWidth-1:0]                mcAddr,
    output logic [memAccessPkg::dataWidth-1:0]  mcData,
    output memAccessPkg::lenT                   mcLen
);

    import memAccessPkg::*;

    typedef enum logic [1:0] {
        stEmpty,
        stIssue,
        stWait,
        stReply
    } slotStateT;

    slotStateT              state;
    logic                   slotStore;
    logic [addrWidth-1:0]   slotAddr;
    logic [dataWidth-1:0]   slotData;
    lenT                    slotLen;
    logic [nickWidth-1:0]   slotNick;

    // **************************************************
    // Slot FSM
    // **************************************************

    // Nothing moves while rdy is low, including the reply.
    assign qPop    = rdy && (state == stEmpty) && qValid;
    assign mcEn    = rdy && (state == stIssue) && !mcBusy;
    assign rspPush = rdy && (state == stReply) && !rspFull;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stEmpty;
        end else if (rdy) begin
            case (state)
                stEmpty: if (qValid) state <= stIssue;
                stIssue: if (!mcBusy) state <= stWait;
                stWait:  if (mcDone) state <= stReply;
                stReply: if (!rspFull) state <= stEmpty;
                default: state <= stEmpty;
            endcase
        end
    end

    // The request is held here for the whole access, nickname included.
    always_ff @(posedge clk) begin
        if (qPop) begin
            slotStore <= qReq.store;
            slotAddr  <= qReq.addr[addrWidth-1:0];
            slotData  <= qReq.data;
            slotLen   <= qReq.len;
            slotNick  <= qReq.nick;
        end
        if (rdy && (state == stWait) && mcDone) begin
            rspData.data <= slotStore ? '0 : mcRdData;
            rspData.nick <= slotNick;
        end
    end

    assign mcStore = slotStore;
    assign mcAddr  = slotAddr;
    assign mcData  = slotData;
    assign mcLen   = slotLen;

    // The controller must report busy on the cycle after it takes an access.
    issueHandshake: assert property (@(posedge clk) disable iff (rst)
        mcEn |=> mcBusy)
        else $error("requestSlot: controller handshake broken");

    legalLength: assert property (@(posedge clk) disable iff (rst)
        qPop |-> (qReq.len != lenIllegal))
        else $error("requestSlot: illegal access length");

endmodule

`default_nettype wire

// File: design/memCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module memCtrl #(
    parameter int addrWidth = 10
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    // Access port from the request slot.
    input  logic                                mcEn,
    input  logic                                mcStore,
    input  logic [addrWidth-1:0]                mcAddr,
    input  logic [memAccessPkg::dataWidth-1:0]  mcData,
    input  memAccessPkg::lenT                   mcLen,
    output logic                                mcBusy,
    output logic                                mcDone,
    output logic [memAccessPkg::dataWidth-1:0]  mcRdData,
    // Byte RAM port.
    output logic                                ramEn,
    output logic                                ramWe,
    output logic [addrWidth-1:0]                ramAddr,
    output logic [7:0]                          ramWrByte,
    input  logic [7:0]                          ramRdByte
);

    import memAccessPkg::*;

    logic                   curStore;
    logic [addrWidth-1:0]   curAddr;
    logic [dataWidth-1:0]   shiftData;
    lenT                    curLen;
    logic [2:0]             nBytes;
    logic [2:0]             issueCnt;
    logic                   issuing;
    logic                   step;
    logic                   capPend;
    logic [1:0]             capIdx;

    always_comb begin
        case (curLen)
            lenByte: nBytes = 3'd1;
            lenHalf: nBytes = 3'd2;
            lenWord: nBytes = 3'd4;
            default: nBytes = 3'd1;
        endcase
    end

    assign issuing = mcBusy && (issueCnt < nBytes);
    assign step    = rdy && issuing;

    // **************************************************
    // RAM drive
    // **************************************************

    // One byte per step, lowest address and lowest byte first.
    assign ramEn     = step;
    assign ramWe     = step && curStore;
    assign ramAddr   = curAddr;
    assign ramWrByte = shiftData[7:0];

    // **************************************************
    // Sequencer
    // **************************************************

    // The step after the last transfer only collects the final read byte
    // and raises mcDone.
    always_ff @(posedge clk) begin
        if (rst) begin
            mcBusy   <= 1'b0;
            mcDone   <= 1'b0;
            capPend  <= 1'b0;
            issueCnt <= '0;
        end else if (rdy) begin
            mcDone  <= 1'b0;
            capPend <= step && !curStore;
            if (mcEn) begin
                mcBusy   <= 1'b1;
                issueCnt <= '0;
            end else if (mcBusy) begin
                if (issuing) begin
                    issueCnt <= issueCnt + 1'b1;
                end else begin
                    mcBusy <= 1'b0;
                    mcDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && mcEn) begin
            curStore  <= mcStore;
            curAddr   <= mcAddr;
            shiftData <= mcData;
            curLen    <= mcLen;
            mcRdData  <= '0;
        end else if (step) begin
            // Address wraps at the top of the RAM.
            curAddr   <= curAddr + 1'b1;
            shiftData <= shiftData >> 8;
            capIdx    <= issueCnt[1:0];
        end
        // Read data lands one cycle after its address went out.
        if (rdy && capPend) begin
            mcRdData[{capIdx, 3'b000} +: 8] <= ramRdByte;
        end
    end

    doneNotWithEnable: assert property (@(posedge clk) disable iff (rst) !(mcDone && mcEn))
        else $error("memCtrl: new access offered during completion");

endmodule

`default_nettype wire

// File: design/byteRam.sv
`timescale 1ns/10ps
`default_nettype none

module byteRam #(
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic                 ramEn,
    input  logic                 ramWe,
    input  logic [addrWidth-1:0] ramAddr,
    input  logic [7:0]           ramWrByte,
    output logic [7:0]           ramRdByte
);

    localparam int ramSize = 1 << addrWidth;

    logic [7:0] mem [ramSize];

    // Single port. A write leaves the read register untouched.
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWrByte;
            end else begin
                ramRdByte <= mem[ramAddr];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/syncFifo.sv
`timescale 1ns/10ps
`default_nettype none

module syncFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    valid,
    output logic    full
);

    localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);

    payloadT                 store [depth];
    logic [ptrWidth-1:0]     wrPtr;
    logic [ptrWidth-1:0]     rdPtr;
    logic [countWidth-1:0]   count;

    // Pointers wrap explicitly so that depth need not be a power of two.
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            store[wrPtr] <= pushData;
        end
    end

    // The head entry is visible without a read cycle.
    assign popData = store[rdPtr];
    assign valid   = (count != '0);
    assign full    = (count == countWidth'(depth));

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("syncFifo: push while full");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst) !(pop && !valid))
        else $error("syncFifo: pop while empty");

endmodule

`default_nettype wire

// File: design/memAccessPkg.sv
`default_nettype none

package memAccessPkg;

    // **************************************************
    // Widths
    // **************************************************

    localparam int dataWidth = 32;
    localparam int nickWidth = 4;

    // Access length as seen on the request port. Code 3 is never legal.
    typedef enum logic [1:0] {
        lenByte    = 2'd0,
        lenHalf    = 2'd1,
        lenWord    = 2'd2,
        lenIllegal = 2'd3
    } lenT;

    // **************************************************
    // Queue payloads
    // **************************************************

    // The RAM only decodes the low address bits.
    typedef struct packed {
        logic                 store;
        logic [31:0]          addr;
        logic [dataWidth-1:0] data;
        lenT                  len;
        logic [nickWidth-1:0] nick;
    } memReqT;

    // Stores come back with a zero data word.
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [nickWidth-1:0] nick;
    } memRespT;

endpackage

`default_nettype wire
